// ==== verilog/issue_pkg.sv ====
package issue_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sizes
    localparam int XLEN        = 32;   // Data and pc width
    localparam int REG_AW      = 5;    // 32 architectural registers
    localparam int ALU_OP_W    = 4;
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_AW    = 3;    // log2 of QUEUE_DEPTH

    ////////////////////////////////////////////////////////////////////////////
    // Instruction class, decides the execute lane
    typedef enum logic [1:0] {
        INST_ALU = 2'd0,               // Either lane
        INST_BR  = 2'd1,               // Either lane
        INST_MUL = 2'd2,               // Lane B only
        INST_DIV = 2'd3                // Lane B only
    } inst_type_t;

    // Decoded packet held in the issue queue, 118 bits
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     pc_pre;     // Predicted next pc
        inst_type_t          inst_type;
        logic [REG_AW-1:0]   rj;         // Source 1
        logic [REG_AW-1:0]   rk;         // Source 2
        logic [REG_AW-1:0]   rd;
        logic                rf_we;
        logic [XLEN-1:0]     imm;
        logic [ALU_OP_W-1:0] alu_op;
    } issue_inst_t;

endpackage

// ==== verilog/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_flush,
    input  logic [1:0]  i_push_valid,    // Bit 0 is the older packet
    input  issue_inst_t i_push_inst0,
    input  issue_inst_t i_push_inst1,
    input  logic        i_pop,
    output logic        o_push_ready,
    output logic [1:0]  o_head_valid,
    output issue_inst_t o_head_inst0,
    output issue_inst_t o_head_inst1
);

    issue_inst_t         mem [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] wr_ptr;
    logic [QUEUE_AW-1:0] rd_ptr;
    logic [QUEUE_AW:0]   count;
    logic [1:0]          push_cnt;
    logic [1:0]          pop_cnt;
    logic                raw_dep;
    logic                pair_ok;

    assign o_push_ready = count <= (QUEUE_AW+1)'(QUEUE_DEPTH - 2);   // Room for a full pair
    assign push_cnt     = {1'b0, i_push_valid[0]} + {1'b0, i_push_valid[1]};
    assign pop_cnt      = i_pop ? {1'b0, o_head_valid[0]} + {1'b0, o_head_valid[1]} : 2'd0;

    assign o_head_inst0 = mem[rd_ptr];
    assign o_head_inst1 = mem[rd_ptr + QUEUE_AW'(1)];

    ////////////////////////////////////////////////////////////////////////////
    // Pairing rule for the two oldest entries
    assign raw_dep = o_head_inst0.rf_we &&
                     ((o_head_inst1.rj == o_head_inst0.rd) ||
                      (o_head_inst1.rk == o_head_inst0.rd));

    // At least one of the pair must be able to sit in lane A
    assign pair_ok = ((o_head_inst0.inst_type == INST_ALU) ||
                      (o_head_inst1.inst_type == INST_ALU)) && !raw_dep;

    assign o_head_valid[0] = count != '0;
    assign o_head_valid[1] = (count >= (QUEUE_AW+1)'(2)) && pair_ok;

    ////////////////////////////////////////////////////////////////////////////
    // Storage and pointers
    always_ff @(posedge clk) begin
        if (i_push_valid[0]) begin
            mem[wr_ptr] <= i_push_inst0;
        end
        if (i_push_valid[1]) begin
            mem[wr_ptr + QUEUE_AW'(i_push_valid[0])] <= i_push_inst1;   // Packs after inst0
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + QUEUE_AW'(push_cnt);
            rd_ptr <= rd_ptr + QUEUE_AW'(pop_cnt);
            count  <= count + (QUEUE_AW+1)'(push_cnt) - (QUEUE_AW+1)'(pop_cnt);
        end
    end

    a_push_when_ready: assert property (
        @(posedge clk) disable iff (!rstn)
        (|i_push_valid) |-> o_push_ready
    ) else $error("issue queue push while not ready");

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rstn)
        count <= (QUEUE_AW+1)'(QUEUE_DEPTH)
    ) else $error("issue queue count overflow");

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import issue_pkg::*;
(
    input  logic              clk,
    input  logic [REG_AW-1:0] i_raddr_a1,
    input  logic [REG_AW-1:0] i_raddr_a2,
    input  logic [REG_AW-1:0] i_raddr_b1,
    input  logic [REG_AW-1:0] i_raddr_b2,
    input  logic              i_we_a,
    input  logic [REG_AW-1:0] i_waddr_a,
    input  logic [XLEN-1:0]   i_wdata_a,
    input  logic              i_we_b,
    input  logic [REG_AW-1:0] i_waddr_b,
    input  logic [XLEN-1:0]   i_wdata_b,
    output logic [XLEN-1:0]   o_rdata_a1,
    output logic [XLEN-1:0]   o_rdata_a2,
    output logic [XLEN-1:0]   o_rdata_b1,
    output logic [XLEN-1:0]   o_rdata_b2
);

    logic [XLEN-1:0] regs [2**REG_AW];
    logic            wr_clash;

    assign wr_clash = i_we_a && i_we_b && (i_waddr_a == i_waddr_b) && (i_waddr_a != '0);

    // Lane b is written last so it wins a clash
    always_ff @(posedge clk) begin
        if (i_we_a && (i_waddr_a != '0)) begin
            regs[i_waddr_a] <= i_wdata_a;
        end
        if (i_we_b && (i_waddr_b != '0)) begin
            regs[i_waddr_b] <= i_wdata_b;
        end
    end

    // No bypass, new data visible from the next cycle
    assign o_rdata_a1 = (i_raddr_a1 == '0) ? '0 : regs[i_raddr_a1];
    assign o_rdata_a2 = (i_raddr_a2 == '0) ? '0 : regs[i_raddr_a2];
    assign o_rdata_b1 = (i_raddr_b1 == '0) ? '0 : regs[i_raddr_b1];
    assign o_rdata_b2 = (i_raddr_b2 == '0) ? '0 : regs[i_raddr_b2];

    // A clash means both execute lanes retired into the same rd
    a_wb_clash: assert property (
        @(posedge clk) !wr_clash
    ) else $warning("both writeback lanes target r%0d, lane b kept", i_waddr_b);

endmodule

// ==== verilog/issue_exe.sv ====
`timescale 1ns/1ps

module issue_exe
    import issue_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_stall,
    input  logic                i_flush,
    input  logic [1:0]          i_head_valid,
    input  issue_inst_t         i_head_inst0,
    input  issue_inst_t         i_head_inst1,
    input  logic [XLEN-1:0]     i_rdata_a1,     // Sources of head inst0
    input  logic [XLEN-1:0]     i_rdata_a2,
    input  logic [XLEN-1:0]     i_rdata_b1,     // Sources of head inst1
    input  logic [XLEN-1:0]     i_rdata_b2,
    output logic                o_pop,
    output logic                o_ex_valid_a,   o_ex_valid_b,
    output logic [XLEN-1:0]     o_ex_pc_a,      o_ex_pc_b,
    output logic [XLEN-1:0]     o_ex_src1_a,    o_ex_src1_b,
    output logic [XLEN-1:0]     o_ex_src2_a,    o_ex_src2_b,
    output logic [XLEN-1:0]     o_ex_imm_a,     o_ex_imm_b,
    output logic [ALU_OP_W-1:0] o_ex_alu_op_a,  o_ex_alu_op_b,
    output logic [REG_AW-1:0]   o_ex_rd_a,      o_ex_rd_b,
    output logic                o_ex_rf_we_a,   o_ex_rf_we_b,
    output logic                o_ex_br_pd_a,   o_ex_br_pd_b,
    output logic [XLEN-1:0]     o_ex_pc_pre_a,  o_ex_pc_pre_b,
    output logic                o_ex_mul_en,
    output logic                o_ex_div_en
);

    logic            swap;
    logic            vld_a;
    logic            vld_b;
    issue_inst_t     inst_a;
    issue_inst_t     inst_b;
    logic [XLEN-1:0] src1_a, src2_a;
    logic [XLEN-1:0] src1_b, src2_b;

    assign o_pop = ~i_stall;
    assign swap  = (i_head_inst0.inst_type != INST_ALU) && (i_head_inst0.inst_type != INST_BR);

    ////////////////////////////////////////////////////////////////////////////
    // Lane steering
    always_comb begin
        if (swap) begin                              // Older mul/div goes to lane B
            vld_a  = i_head_valid[1];
            vld_b  = i_head_valid[0];
            inst_a = i_head_inst1;
            inst_b = i_head_inst0;
            src1_a = i_rdata_b1;
            src2_a = i_rdata_b2;
            src1_b = i_rdata_a1;
            src2_b = i_rdata_a2;
        end else begin
            vld_a  = i_head_valid[0];
            vld_b  = i_head_valid[1];
            inst_a = i_head_inst0;
            inst_b = i_head_inst1;
            src1_a = i_rdata_a1;
            src2_a = i_rdata_a2;
            src1_b = i_rdata_b1;
            src2_b = i_rdata_b2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute registers
    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            o_ex_valid_a <= 1'b0;
            o_ex_valid_b <= 1'b0;
            o_ex_rf_we_a <= 1'b0;
            o_ex_rf_we_b <= 1'b0;
            o_ex_br_pd_a <= 1'b0;
            o_ex_br_pd_b <= 1'b0;
            o_ex_mul_en  <= 1'b0;
            o_ex_div_en  <= 1'b0;
        end else if (!i_stall) begin
            o_ex_valid_a <= vld_a;
            o_ex_valid_b <= vld_b;
            o_ex_rf_we_a <= vld_a & inst_a.rf_we;
            o_ex_rf_we_b <= vld_b & inst_b.rf_we;
            o_ex_br_pd_a <= vld_a & (inst_a.pc_pre != inst_a.pc + XLEN'(4));   // Predicted taken
            o_ex_br_pd_b <= vld_b & (inst_b.pc_pre != inst_b.pc + XLEN'(4));
            o_ex_mul_en  <= vld_b & (inst_b.inst_type == INST_MUL);
            o_ex_div_en  <= vld_b & (inst_b.inst_type == INST_DIV);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_ex_pc_a     <= inst_a.pc;
            o_ex_pc_b     <= inst_b.pc;
            o_ex_src1_a   <= src1_a;
            o_ex_src1_b   <= src1_b;
            o_ex_src2_a   <= src2_a;
            o_ex_src2_b   <= src2_b;
            o_ex_imm_a    <= inst_a.imm;
            o_ex_imm_b    <= inst_b.imm;
            o_ex_alu_op_a <= inst_a.alu_op;
            o_ex_alu_op_b <= inst_b.alu_op;
            o_ex_rd_a     <= inst_a.rd;
            o_ex_rd_b     <= inst_b.rd;
            o_ex_pc_pre_a <= inst_a.pc_pre;
            o_ex_pc_pre_b <= inst_b.pc_pre;
        end
    end

    // Holds only while the queue never pairs two non-ALU entries
    a_lane_a_simple: assert property (
        @(posedge clk) disable iff (!rstn)
        (vld_a && !i_stall && !i_flush) |-> !(inst_a.inst_type inside {INST_MUL, INST_DIV})
    ) else $error("mul/div steered into lane A");

endmodule

// ==== verilog/issue_top.sv ====
`timescale 1ns/1ps

module issue_top
    import issue_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_stall,
    input  logic                i_flush,
    input  logic [1:0]          i_push_valid,
    input  issue_inst_t         i_push_inst0,
    input  issue_inst_t         i_push_inst1,
    output logic                o_push_ready,
    input  logic                i_wb_we_a,      i_wb_we_b,
    input  logic [REG_AW-1:0]   i_wb_addr_a,    i_wb_addr_b,
    input  logic [XLEN-1:0]     i_wb_data_a,    i_wb_data_b,
    output logic                o_ex_valid_a,   o_ex_valid_b,
    output logic [XLEN-1:0]     o_ex_pc_a,      o_ex_pc_b,
    output logic [XLEN-1:0]     o_ex_src1_a,    o_ex_src1_b,
    output logic [XLEN-1:0]     o_ex_src2_a,    o_ex_src2_b,
    output logic [XLEN-1:0]     o_ex_imm_a,     o_ex_imm_b,
    output logic [ALU_OP_W-1:0] o_ex_alu_op_a,  o_ex_alu_op_b,
    output logic [REG_AW-1:0]   o_ex_rd_a,      o_ex_rd_b,
    output logic                o_ex_rf_we_a,   o_ex_rf_we_b,
    output logic                o_ex_br_pd_a,   o_ex_br_pd_b,
    output logic [XLEN-1:0]     o_ex_pc_pre_a,  o_ex_pc_pre_b,
    output logic                o_ex_mul_en,
    output logic                o_ex_div_en
);

    logic [1:0]      head_valid;
    issue_inst_t     head_inst0;
    issue_inst_t     head_inst1;
    logic            pop;
    logic [XLEN-1:0] rdata_a1, rdata_a2;
    logic [XLEN-1:0] rdata_b1, rdata_b2;

    issue_queue u_queue (
        .i_pop        (pop),
        .o_head_valid (head_valid),
        .o_head_inst0 (head_inst0),
        .o_head_inst1 (head_inst1),
        .*
    );

    // Head operands read straight from the queue outputs
    reg_file u_rf (
        .clk        (clk),
        .i_raddr_a1 (head_inst0.rj),
        .i_raddr_a2 (head_inst0.rk),
        .i_raddr_b1 (head_inst1.rj),
        .i_raddr_b2 (head_inst1.rk),
        .i_we_a     (i_wb_we_a),
        .i_waddr_a  (i_wb_addr_a),
        .i_wdata_a  (i_wb_data_a),
        .i_we_b     (i_wb_we_b),
        .i_waddr_b  (i_wb_addr_b),
        .i_wdata_b  (i_wb_data_b),
        .o_rdata_a1 (rdata_a1),
        .o_rdata_a2 (rdata_a2),
        .o_rdata_b1 (rdata_b1),
        .o_rdata_b2 (rdata_b2)
    );

    issue_exe u_exe (
        .i_head_valid (head_valid),
        .i_head_inst0 (head_inst0),
        .i_head_inst1 (head_inst1),
        .i_rdata_a1   (rdata_a1),
        .i_rdata_a2   (rdata_a2),
        .i_rdata_b1   (rdata_b1),
        .i_rdata_b2   (rdata_b2),
        .o_pop        (pop),
        .*
    );

endmodule

// ==== tests/tb_issue_top.sv ====
`timescale 1ns/1ps

module tb_issue_top
    import issue_pkg::*;
();

    logic                clk;
    logic                rstn;
    logic                i_stall, i_flush;
    logic [1:0]          i_push_valid;
    issue_inst_t         i_push_inst0, i_push_inst1;
    logic                o_push_ready;
    logic                i_wb_we_a, i_wb_we_b;
    logic [REG_AW-1:0]   i_wb_addr_a, i_wb_addr_b;
    logic [XLEN-1:0]     i_wb_data_a, i_wb_data_b;
    logic                o_ex_valid_a, o_ex_valid_b;
    logic [XLEN-1:0]     o_ex_pc_a, o_ex_pc_b, o_ex_src1_a, o_ex_src1_b;
    logic [XLEN-1:0]     o_ex_src2_a, o_ex_src2_b, o_ex_imm_a, o_ex_imm_b;
    logic [ALU_OP_W-1:0] o_ex_alu_op_a, o_ex_alu_op_b;
    logic [REG_AW-1:0]   o_ex_rd_a, o_ex_rd_b;
    logic                o_ex_rf_we_a, o_ex_rf_we_b, o_ex_br_pd_a, o_ex_br_pd_b;
    logic [XLEN-1:0]     o_ex_pc_pre_a, o_ex_pc_pre_b;
    logic                o_ex_mul_en, o_ex_div_en;

    int              errors = 0;
    int              seed = 32'h2b9a436d;
    logic [XLEN-1:0] mirror [32];          // Expected register contents
    issue_inst_t     exp_q [$];            // Pushed and not yet issued

    issue_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_val(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic issue_inst_t make_inst(input inst_type_t t);
        issue_inst_t p;
        p.pc        = {XLEN'($random(seed)) & 32'hffff_fffc};
        p.pc_pre    = ($random(seed) & 1) ? p.pc + XLEN'(4) : XLEN'($random(seed));
        p.inst_type = t;
        p.rj        = REG_AW'($random(seed));
        p.rk        = REG_AW'($random(seed));
        p.rd        = REG_AW'($random(seed));
        p.rf_we     = 1'($random(seed));
        p.imm       = XLEN'($random(seed));
        p.alu_op    = ALU_OP_W'($random(seed));
        return p;
    endfunction

    // Younger may join the older only with an ALU in the pair and no RAW
    function automatic bit can_pair(input issue_inst_t o, input issue_inst_t y);
        return ((o.inst_type == INST_ALU) || (y.inst_type == INST_ALU)) &&
               !(o.rf_we && ((y.rj == o.rd) || (y.rk == o.rd)));
    endfunction

    task automatic preload_regs();
        int i;
        mirror[0] = '0;
        for (i = 1; i < 32; i += 2) begin
            @(posedge clk);
            #1;
            i_wb_we_a   = 1'b1;
            i_wb_addr_a = REG_AW'(i);
            i_wb_data_a = XLEN'($random(seed));
            mirror[i]   = i_wb_data_a;
            i_wb_we_b   = (i < 31);
            i_wb_addr_b = REG_AW'(i + 1);
            i_wb_data_b = XLEN'($random(seed));
            if (i < 31) mirror[i+1] = i_wb_data_b;
        end
        @(posedge clk);
        #1;
        i_wb_we_a = 1'b0;
        i_wb_we_b = 1'b0;
    endtask

    task automatic push_pair(input bit v0, input issue_inst_t p0,
                             input bit v1, input issue_inst_t p1);
        int n;
        @(posedge clk);
        #1;
        for (n = 0; n < 20 && !o_push_ready; n++) begin
            @(posedge clk);
            #1;
        end
        assert (o_push_ready) else begin
            errors++;
            $display("Timed out at %0t waiting for the queue to accept a push", $time);
        end
        i_push_valid = {v1, v0};
        i_push_inst0 = p0;
        i_push_inst1 = p1;
        if (v0) exp_q.push_back(p0);
        if (v1) exp_q.push_back(p1);
        @(posedge clk);
        #1;
        i_push_valid = 2'b00;
    endtask

    task automatic wait_issue(output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < 20 && !seen; n++) begin
            @(negedge clk);                           // Outputs settled here
            seen = o_ex_valid_a || o_ex_valid_b;
        end
    endtask

    task automatic check_lane(input string ln, input bit ev, input issue_inst_t e,
                              input logic v, input logic [XLEN-1:0] pc,
                              input logic [XLEN-1:0] s1, input logic [XLEN-1:0] s2,
                              input logic [XLEN-1:0] imm, input logic [ALU_OP_W-1:0] op,
                              input logic [REG_AW-1:0] rd, input logic we, input logic pd,
                              input logic [XLEN-1:0] ppre);
        check_val(XLEN'(v), XLEN'(ev), {ln, " valid"});
        check_val(XLEN'(we), XLEN'(ev & e.rf_we), {ln, " rf_we"});
        if (ev) begin
            check_val(pc, e.pc, {ln, " pc"});
            check_val(s1, mirror[e.rj], {ln, " src1"});
            check_val(s2, mirror[e.rk], {ln, " src2"});
            check_val(imm, e.imm, {ln, " imm"});
            check_val(XLEN'(op), XLEN'(e.alu_op), {ln, " alu_op"});
            check_val(XLEN'(rd), XLEN'(e.rd), {ln, " rd"});
            check_val(ppre, e.pc_pre, {ln, " pc_pre"});
            check_val(XLEN'(pd), XLEN'((e.pc_pre - e.pc) != XLEN'(4)), {ln, " br_pd"});
        end
    endtask

    // Issue everything in exp_q and predict pairing and lane steering
    task automatic drain_expected();
        issue_inst_t ia, ib, older, younger;
        bit          pair, swap, va, vb, seen;
        bit          lane_a_muldiv;
        while (exp_q.size() > 0) begin
            older   = exp_q[0];
            younger = (exp_q.size() > 1) ? exp_q[1] : older;
            pair    = (exp_q.size() > 1) && can_pair(older, younger);
            swap    = (older.inst_type == INST_MUL) || (older.inst_type == INST_DIV);
            ia = swap ? younger : older;
            ib = swap ? older : younger;
            va = swap ? pair : 1'b1;
            vb = swap ? 1'b1 : pair;
            wait_issue(seen);
            assert (seen) else begin
                errors++;
                $display("Timed out at %0t waiting for an issue", $time);
            end
            check_lane("lane A", va, ia, o_ex_valid_a, o_ex_pc_a, o_ex_src1_a, o_ex_src2_a,
                       o_ex_imm_a, o_ex_alu_op_a, o_ex_rd_a, o_ex_rf_we_a, o_ex_br_pd_a,
                       o_ex_pc_pre_a);
            check_lane("lane B", vb, ib, o_ex_valid_b, o_ex_pc_b, o_ex_src1_b, o_ex_src2_b,
                       o_ex_imm_b, o_ex_alu_op_b, o_ex_rd_b, o_ex_rf_we_b, o_ex_br_pd_b,
                       o_ex_pc_pre_b);
            check_val(XLEN'(o_ex_mul_en), XLEN'(vb && ib.inst_type == INST_MUL), "mul_en");
            check_val(XLEN'(o_ex_div_en), XLEN'(vb && ib.inst_type == INST_DIV), "div_en");
            lane_a_muldiv = o_ex_valid_a &&
                (((older.inst_type inside {INST_MUL, INST_DIV}) &&
                  (o_ex_pc_a === older.pc)) ||
                 ((exp_q.size() > 1) && (younger.inst_type inside {INST_MUL, INST_DIV}) &&
                  (o_ex_pc_a === younger.pc)));
            assert (!lane_a_muldiv) else begin
                errors++;
                $display("A multiply or divide was issued in lane A at %0t", $time);
            end
            void'(exp_q.pop_front());
            if (pair) void'(exp_q.pop_front());
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset_state();
        check_val(XLEN'({o_ex_valid_a, o_ex_valid_b}), '0, "lane valids");
        check_val(XLEN'({o_ex_rf_we_a, o_ex_rf_we_b, o_ex_mul_en, o_ex_div_en}), '0, "enables");
        check_val(XLEN'(o_push_ready), 32'd1, "push_ready");
    endtask

    task automatic test_single_alu();
        preload_regs();
        push_pair(1'b1, make_inst(INST_ALU), 1'b0, make_inst(INST_ALU));
        drain_expected();
    endtask

    task automatic test_pairs();
        issue_inst_t p0, p1;
        p0 = make_inst(INST_MUL);
        p1 = make_inst(INST_ALU);
        p0.rf_we = 1'b0;                             // Keep the pair free of RAW
        push_pair(1'b1, p0, 1'b1, p1);
        drain_expected();
        p0 = make_inst(INST_ALU);
        p1 = make_inst(INST_DIV);
        p0.rf_we = 1'b0;
        push_pair(1'b1, p0, 1'b1, p1);
        drain_expected();
    endtask

    task automatic test_serial();
        issue_inst_t p0, p1;
        push_pair(1'b1, make_inst(INST_DIV), 1'b1, make_inst(INST_MUL));
        drain_expected();
        push_pair(1'b1, make_inst(INST_BR), 1'b1, make_inst(INST_MUL));
        drain_expected();
        p0 = make_inst(INST_ALU);
        p1 = make_inst(INST_ALU);
        p0.rf_we = 1'b1;
        p1.rk    = p0.rd;                            // RAW on the older rd
        push_pair(1'b1, p0, 1'b1, p1);
        drain_expected();
    endtask

    task automatic test_stall();
        logic            v_snap;
        logic [XLEN-1:0] pc_snap;
        int              n;
        @(posedge clk);
        #1;
        i_stall = 1'b1;
        v_snap  = o_ex_valid_a;
        pc_snap = o_ex_pc_a;
        for (n = 0; n < 8 && o_push_ready; n++) begin
            push_pair(1'b1, make_inst(INST_ALU), 1'b1, make_inst(inst_type_t'(n % 4)));
        end
        check_val(XLEN'(o_push_ready), '0, "push_ready under stall");
        check_val(XLEN'(o_ex_valid_a), XLEN'(v_snap), "held lane A valid");
        check_val(o_ex_pc_a, pc_snap, "held lane A pc");
        i_stall = 1'b0;
        drain_expected();
    endtask

    task automatic test_flush();
        int n;
        push_pair(1'b1, make_inst(INST_ALU), 1'b1, make_inst(INST_BR));
        @(posedge clk);
        #1;
        i_stall = 1'b1;
        check_val(XLEN'(o_ex_valid_a), 32'd1, "lane A valid before flush");
        push_pair(1'b1, make_inst(INST_MUL), 1'b0, make_inst(INST_ALU));
        exp_q.delete();                              // Flushed entries never issue
        i_flush = 1'b1;
        @(posedge clk);
        #1;
        i_flush = 1'b0;
        i_stall = 1'b0;
        for (n = 0; n < 8; n++) begin
            @(negedge clk);
            check_val(XLEN'({o_ex_valid_a, o_ex_valid_b}), '0, "valids after flush");
        end
        push_pair(1'b1, make_inst(INST_ALU), 1'b0, make_inst(INST_ALU));
        drain_expected();
    endtask

    initial begin
        rstn = 1'b0;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_push_valid = 2'b00;
        i_push_inst0 = '0;
        i_push_inst1 = '0;
        i_wb_we_a = 1'b0;
        i_wb_we_b = 1'b0;
        i_wb_addr_a = '0;
        i_wb_addr_b = '0;
        i_wb_data_a = '0;
        i_wb_data_b = '0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset_state();
        test_single_alu();
        test_pairs();
        test_serial();
        test_stall();
        test_flush();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/issue_pkg.sv
verilog/issue_queue.sv
verilog/reg_file.sv
verilog/issue_exe.sv
verilog/issue_top.sv
tests/tb_issue_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_issue_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
